// File: logic/dcache_settings.svh
// geometry is fixed at 2 ways, 16 sets, 4-word lines; replacement assumes exactly 2 ways
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// set index and word offset
`define DCACHE_INDEX_W   4
`define DCACHE_OFFSET_W  2
`define DCACHE_WAYS      2

// derived geometry
`define DCACHE_SETS      (1 << `DCACHE_INDEX_W)
`define DCACHE_WORDS     (1 << `DCACHE_OFFSET_W)
`define DCACHE_LINE_W    (32 * `DCACHE_WORDS)
`define DCACHE_TAG_W     (32 - `DCACHE_INDEX_W - `DCACHE_OFFSET_W - 2)

// address field positions, byte bits sit below the offset
`define DCACHE_INDEX_LSB (`DCACHE_OFFSET_W + 2)
`define DCACHE_TAG_LSB   (`DCACHE_INDEX_W + `DCACHE_OFFSET_W + 2)

`endif

// File: logic/dcache_pkg.sv
// types shared by the cache controller, request buffer and top ports; no geometry here
package dcache_pkg;

    // controller states
    typedef enum logic [2:0] {
        state_idle,
        state_lookup,
        state_refill_req,
        state_refill_wait,
        state_write_req,
        state_write_wait
    } dcache_state_t;

    // processor request kind
    typedef enum logic {
        kind_load,
        kind_store
    } dcache_kind_t;

endpackage

// File: logic/dcache_req_buffer.sv
// holds one accepted request for the whole transaction; reset leaves a zero-address load
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_req_buffer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          capture,
    input  dcache_pkg::dcache_kind_t      kind,
    input  logic [31:0]                   addr,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    output dcache_pkg::dcache_kind_t      buf_kind,
    output logic [31:0]                   buf_addr,
    output logic [`DCACHE_TAG_W-1:0]      buf_tag,
    output logic [`DCACHE_INDEX_W-1:0]    buf_index,
    output logic [`DCACHE_OFFSET_W-1:0]   buf_offset,
    output logic [31:0]                   buf_wdata,
    output logic [3:0]                    buf_wstrb
);

    import dcache_pkg::*;

    // payload, loaded at the accept edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_kind  <= kind_load;
            buf_addr  <= '0;
            buf_wdata <= '0;
            buf_wstrb <= '0;
        end else if (capture) begin
            buf_kind  <= kind;
            buf_addr  <= addr;
            buf_wdata <= wdata;
            buf_wstrb <= wstrb;
        end
    end

    // address fields
    assign buf_tag    = buf_addr[31:`DCACHE_TAG_LSB];
    assign buf_index  = buf_addr[`DCACHE_TAG_LSB-1:`DCACHE_INDEX_LSB];
    assign buf_offset = buf_addr[`DCACHE_INDEX_LSB-1:2];

endmodule

// File: logic/dcache_way.sv
// one cache way; read data and hit appear one cycle after rd_index, word writes land only on a hit
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_way (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`DCACHE_INDEX_W-1:0]    rd_index,
    input  logic [`DCACHE_TAG_W-1:0]      cmp_tag,
    input  logic [`DCACHE_INDEX_W-1:0]    wr_index,
    input  logic [`DCACHE_OFFSET_W-1:0]   wr_offset,
    input  logic                          word_we,
    input  logic                          line_we,
    input  logic [31:0]                   word_data,
    input  logic [3:0]                    word_strb,
    input  logic [`DCACHE_LINE_W-1:0]     line_data,
    output logic                          hit,
    output logic [`DCACHE_LINE_W-1:0]     rd_line
);

    logic [`DCACHE_TAG_W-1:0]  tag_mem [`DCACHE_SETS];
    logic [`DCACHE_LINE_W-1:0] data_mem [`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]   valid_q;
    logic [`DCACHE_TAG_W-1:0]  rd_tag_q;
    logic                      rd_valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[rd_index];
            if (line_we) begin
                valid_q[wr_index] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tag and line arrays
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_tag_q <= tag_mem[rd_index];
        rd_line  <= data_mem[rd_index];
        if (line_we) begin
            tag_mem[wr_index]  <= cmp_tag;
            data_mem[wr_index] <= line_data;
        end else if (word_we && hit) begin
            // merge strobed bytes into the addressed word
            for (int b = 0; b < 4; b++) begin
                if (word_strb[b]) begin
                    data_mem[wr_index][wr_offset*32 + b*8 +: 8] <= word_data[b*8 +: 8];
                end
            end
        end
    end

    // compare against the registered read
    assign hit = rd_valid_q && (rd_tag_q == cmp_tag);

endmodule

// File: logic/dcache_way_merge.sv
// assumes exactly two ways and at most one hitting way; replacement is one bit per set
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_way_merge (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`DCACHE_WAYS-1:0]       way_hit,
    input  logic [`DCACHE_LINE_W-1:0]     way_line0,
    input  logic [`DCACHE_LINE_W-1:0]     way_line1,
    input  logic [`DCACHE_LINE_W-1:0]     refill_line,
    input  logic                          use_refill,
    input  logic [`DCACHE_OFFSET_W-1:0]   word_sel,
    input  logic [`DCACHE_INDEX_W-1:0]    index,
    input  logic                          lookup_done,
    input  logic                          refill_done,
    output logic                          any_hit,
    output logic                          victim,
    output logic [31:0]                   rdata
);

    logic [`DCACHE_SETS-1:0]   repl_q;
    logic                      hit_way;
    logic [`DCACHE_LINE_W-1:0] sel_line;

    assign any_hit = |way_hit;
    assign hit_way = way_hit[1];

    ////////////////////////////////////////////////////////////////////////////
    // data path
    ////////////////////////////////////////////////////////////////////////////

    // refill line bypasses the arrays while it is being written
    always_comb begin
        if (use_refill) begin
            sel_line = refill_line;
        end else if (hit_way) begin
            sel_line = way_line1;
        end else begin
            sel_line = way_line0;
        end
    end

    assign rdata = sel_line[word_sel*32 +: 32];

    ////////////////////////////////////////////////////////////////////////////
    // replacement bits
    ////////////////////////////////////////////////////////////////////////////

    // bit names the way to fill next, so it moves away from the last used way
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            repl_q <= '0;
        end else if (refill_done) begin
            repl_q[index] <= ~victim;
        end else if (lookup_done) begin
            repl_q[index] <= ~hit_way;
        end
    end

    assign victim = repl_q[index];

endmodule

// File: logic/dcache_ctrl.sv
// one request in flight; store responds the cycle after bvalid, load miss forwards on data_ok
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          cpu_valid,
    input  dcache_pkg::dcache_kind_t      cpu_kind,
    output logic                          cpu_ready,
    output logic                          resp_valid,
    input  logic                          any_hit,
    input  logic                          victim,
    input  dcache_pkg::dcache_kind_t      buf_kind,
    input  logic [31:0]                   buf_addr,
    input  logic [31:0]                   buf_wdata,
    input  logic [3:0]                    buf_wstrb,
    output logic                          capture,
    output logic [`DCACHE_WAYS-1:0]       way_word_we,
    output logic [`DCACHE_WAYS-1:0]       way_line_we,
    output logic                          use_refill,
    output logic                          lookup_done,
    output logic                          refill_done,
    output logic                          mem_req,
    output logic                          mem_wr,
    output logic [31:0]                   mem_addr,
    output logic [31:0]                   mem_wdata,
    output logic [3:0]                    mem_wstrb,
    input  logic                          mem_addr_ok,
    input  logic                          mem_data_ok,
    input  logic                          mem_bvalid
);

    import dcache_pkg::*;

    dcache_state_t state_q;
    dcache_state_t state_d;
    logic          write_done_q;
    logic          mem_wr_q;
    logic          load_q;
    logic          fill;

    assign cpu_ready = (state_q == state_idle);
    assign capture   = cpu_valid && cpu_ready;
    assign load_q    = (buf_kind == kind_load);

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            state_idle:        if (capture) state_d = state_lookup;
            state_lookup: begin
                if (!load_q) begin
                    state_d = state_write_req;
                end else if (any_hit) begin
                    state_d = state_idle;
                end else begin
                    state_d = state_refill_req;
                end
            end
            state_refill_req:  if (mem_addr_ok) state_d = state_refill_wait;
            state_refill_wait: if (mem_data_ok) state_d = state_idle;
            state_write_req:   if (mem_addr_ok) state_d = state_write_wait;
            state_write_wait:  if (write_done_q) state_d = state_idle;
            default:           state_d = state_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= state_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // bvalid may come as early as the address accept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_done_q <= 1'b0;
        end else if (state_q == state_write_wait && write_done_q) begin
            write_done_q <= 1'b0;
        end else if ((state_q == state_write_req || state_q == state_write_wait) && mem_bvalid) begin
            write_done_q <= 1'b1;
        end
    end

    // write flag comes straight from a flop for the memory side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wr_q <= 1'b0;
        end else if (capture) begin
            mem_wr_q <= (cpu_kind == kind_store);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // way control and response
    ////////////////////////////////////////////////////////////////////////////

    assign fill        = (state_q == state_refill_wait) && mem_data_ok;
    assign use_refill  = (state_q == state_refill_wait);
    assign lookup_done = (state_q == state_lookup) && any_hit;
    assign refill_done = fill;

    // each way drops the word write unless it hit
    assign way_word_we = {`DCACHE_WAYS{(state_q == state_lookup) && !load_q && any_hit}};

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_line_we[w] = fill && (victim == w[0]);
        end
    end

    assign resp_valid = ((state_q == state_lookup) && load_q && any_hit)
                      || fill
                      || ((state_q == state_write_wait) && write_done_q);

    ////////////////////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////////////////////

    assign mem_req   = (state_q == state_refill_req) || (state_q == state_write_req);
    assign mem_wr    = mem_wr_q;
    // line reads are aligned, writes keep the word address
    assign mem_addr  = mem_wr_q ? buf_addr
                                : {buf_addr[31:`DCACHE_INDEX_LSB], {`DCACHE_INDEX_LSB{1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

endmodule

// File: logic/dcache_top.sv
// write-through, no write allocate, 2-way data cache; memory must return whole lines on reads
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cpu_valid,
    input  dcache_pkg::dcache_kind_t  cpu_kind,
    input  logic [31:0]               cpu_addr,
    input  logic [31:0]               cpu_wdata,
    input  logic [3:0]                cpu_wstrb,
    output logic                      cpu_ready,
    output logic                      resp_valid,
    output logic [31:0]               resp_rdata,
    output logic                      mem_req,
    output logic                      mem_wr,
    output logic [31:0]               mem_addr,
    output logic [31:0]               mem_wdata,
    output logic [3:0]                mem_wstrb,
    input  logic                      mem_addr_ok,
    input  logic                      mem_data_ok,
    input  logic                      mem_bvalid,
    input  logic [`DCACHE_LINE_W-1:0] mem_rline
);

    dcache_pkg::dcache_kind_t        buf_kind;
    logic [31:0]                     buf_addr;
    logic [`DCACHE_TAG_W-1:0]        buf_tag;
    logic [`DCACHE_INDEX_W-1:0]      buf_index;
    logic [`DCACHE_OFFSET_W-1:0]     buf_offset;
    logic [31:0]                     buf_wdata;
    logic [3:0]                      buf_wstrb;
    logic                            capture;
    logic [`DCACHE_WAYS-1:0]         way_hit;
    logic [`DCACHE_WAYS-1:0]         way_word_we;
    logic [`DCACHE_WAYS-1:0]         way_line_we;
    logic [`DCACHE_LINE_W-1:0]       way_line [`DCACHE_WAYS];
    logic                            any_hit;
    logic                            victim;
    logic                            use_refill;
    logic                            lookup_done;
    logic                            refill_done;

    dcache_req_buffer req_buffer_inst (
        .clk(clk), .arst_n(arst_n), .capture(capture),
        .kind(cpu_kind), .addr(cpu_addr), .wdata(cpu_wdata), .wstrb(cpu_wstrb),
        .buf_kind(buf_kind), .buf_addr(buf_addr), .buf_tag(buf_tag),
        .buf_index(buf_index), .buf_offset(buf_offset),
        .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb)
    );

    // arrays are read with the live index so data is ready in lookup
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_way way_inst (
            .clk(clk), .arst_n(arst_n),
            .rd_index(cpu_addr[`DCACHE_TAG_LSB-1:`DCACHE_INDEX_LSB]),
            .cmp_tag(buf_tag), .wr_index(buf_index), .wr_offset(buf_offset),
            .word_we(way_word_we[w]), .line_we(way_line_we[w]),
            .word_data(buf_wdata), .word_strb(buf_wstrb), .line_data(mem_rline),
            .hit(way_hit[w]), .rd_line(way_line[w])
        );
    end

    dcache_way_merge way_merge_inst (
        .clk(clk), .arst_n(arst_n), .way_hit(way_hit),
        .way_line0(way_line[0]), .way_line1(way_line[1]), .refill_line(mem_rline),
        .use_refill(use_refill), .word_sel(buf_offset), .index(buf_index),
        .lookup_done(lookup_done), .refill_done(refill_done),
        .any_hit(any_hit), .victim(victim), .rdata(resp_rdata)
    );

    dcache_ctrl ctrl_inst (
        .clk(clk), .arst_n(arst_n), .cpu_valid(cpu_valid), .cpu_kind(cpu_kind),
        .cpu_ready(cpu_ready), .resp_valid(resp_valid), .any_hit(any_hit), .victim(victim),
        .buf_kind(buf_kind), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
        .buf_wstrb(buf_wstrb), .capture(capture), .way_word_we(way_word_we),
        .way_line_we(way_line_we), .use_refill(use_refill), .lookup_done(lookup_done),
        .refill_done(refill_done), .mem_req(mem_req), .mem_wr(mem_wr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_bvalid(mem_bvalid)
    );

endmodule

// File: verification/dcache_mem_model.sv
// line-wide memory with random accept and response delays; serves one request at a time
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_mem_model (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      mem_req,
    input  logic                      mem_wr,
    input  logic [31:0]               mem_addr,
    input  logic [31:0]               mem_wdata,
    input  logic [3:0]                mem_wstrb,
    output logic                      mem_addr_ok,
    output logic                      mem_data_ok,
    output logic                      mem_bvalid,
    output logic [`DCACHE_LINE_W-1:0] mem_rline
);

    // written words only, everything else reads the fill pattern
    logic [31:0] mem [logic [31:0]];
    logic        req_wr;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;

    // fill depends on the whole word address
    function automatic logic [31:0] read_word(input logic [31:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return (waddr * 32'h9e3779b1) ^ 32'h0f1e2d3c;
    endfunction

    initial begin
        logic [31:0] word;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_bvalid  = 1'b0;
        mem_rline   = '0;
        forever begin
            @(negedge clk);
            if (arst_n && mem_req) begin
                // back-pressure before the address is taken
                repeat ($urandom_range(0, 3)) @(negedge clk);
                req_wr      = mem_wr;
                req_addr    = mem_addr;
                req_wdata   = mem_wdata;
                req_wstrb   = mem_wstrb;
                mem_addr_ok = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                if (req_wr) begin
                    word = read_word({req_addr[31:2], 2'b00});
                    for (int b = 0; b < 4; b++) begin
                        if (req_wstrb[b]) begin
                            word[b*8 +: 8] = req_wdata[b*8 +: 8];
                        end
                    end
                    mem[{req_addr[31:2], 2'b00}] = word;
                end
                repeat ($urandom_range(0, 4)) @(negedge clk);
                if (req_wr) begin
                    mem_bvalid = 1'b1;
                end else begin
                    for (int w = 0; w < `DCACHE_WORDS; w++) begin
                        mem_rline[w*32 +: 32] = read_word(req_addr + 32'(w * 4));
                    end
                    mem_data_ok = 1'b1;
                end
                @(negedge clk);
                mem_bvalid  = 1'b0;
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

// File: verification/dcache_assertions.sv
// protocol checks bound into the cache top; all checks are off while reset is low
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_assertions (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    mem_req,
    input logic                    mem_addr_ok,
    input logic                    mem_wr,
    input logic [31:0]             mem_addr,
    input logic [31:0]             mem_wdata,
    input logic [3:0]              mem_wstrb,
    input logic                    resp_valid,
    input logic                    cpu_ready,
    input logic [`DCACHE_WAYS-1:0] way_hit
);

    // request and its fields hold until taken
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr) && $stable(mem_wr)
            && $stable(mem_wdata) && $stable(mem_wstrb))
    else $error("mem_req dropped or changed before mem_addr_ok");

    assert property (@(posedge clk) disable iff (!arst_n) !(&way_hit))
    else $error("both ways hit at once");

    assert property (@(posedge clk) disable iff (!arst_n) resp_valid |-> !cpu_ready)
    else $error("resp_valid while cpu_ready is high");

endmodule

bind dcache_top dcache_assertions assertions_inst (
    .clk(clk),
    .arst_n(arst_n),
    .mem_req(mem_req),
    .mem_addr_ok(mem_addr_ok),
    .mem_wr(mem_wr),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .resp_valid(resp_valid),
    .cpu_ready(cpu_ready),
    .way_hit(way_hit)
);

// File: verification/dcache_tb.sv
// one request in flight; shadow memory fill must match the memory model's fill pattern
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

    import dcache_pkg::*;

    localparam int DIRECTED_TXNS  = 40;
    localparam int RANDOM_TXNS    = 360;
    localparam int TIMEOUT_CYCLES = (DIRECTED_TXNS + RANDOM_TXNS) * 30;

    logic                      clk;
    logic                      arst_n;
    logic                      cpu_valid;
    dcache_kind_t              cpu_kind;
    logic [31:0]               cpu_addr;
    logic [31:0]               cpu_wdata;
    logic [3:0]                cpu_wstrb;
    logic                      cpu_ready;
    logic                      resp_valid;
    logic [31:0]               resp_rdata;
    logic                      mem_req;
    logic                      mem_wr;
    logic [31:0]               mem_addr;
    logic [31:0]               mem_wdata;
    logic [3:0]                mem_wstrb;
    logic                      mem_addr_ok;
    logic                      mem_data_ok;
    logic                      mem_bvalid;
    logic [`DCACHE_LINE_W-1:0] mem_rline;

    // shadow memory and tag model
    logic [31:0]               shadow [logic [31:0]];
    logic [`DCACHE_TAG_W-1:0]  tag_m [`DCACHE_SETS][2];
    logic                      valid_m [`DCACHE_SETS][2];
    logic                      repl_m [`DCACHE_SETS];

    // expectation for the request in flight
    dcache_kind_t exp_kind;
    logic [31:0]  exp_addr;
    logic [31:0]  exp_data;
    logic [31:0]  exp_wdata;
    logic [3:0]   exp_wstrb;
    logic         exp_miss;
    logic         pending;
    int           accept_cycle;
    int           rd_seen;
    int           wr_seen;
    int           resp_cnt;
    int           err_cnt;
    int           cycle_cnt;

    dcache_top dcache_top_inst (.*);

    dcache_mem_model mem_model_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] ref_load_word(input logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:2], 2'b00};
        if (shadow.exists(waddr)) begin
            return shadow[waddr];
        end
        return (waddr * 32'h9e3779b1) ^ 32'h0f1e2d3c;
    endfunction

    // way holding the line, or -1
    function automatic int find_way(input logic [31:0] addr);
        int idx;
        idx = int'(addr[`DCACHE_TAG_LSB-1:`DCACHE_INDEX_LSB]);
        for (int w = 0; w < 2; w++) begin
            if (valid_m[idx][w] && tag_m[idx][w] == addr[31:`DCACHE_TAG_LSB]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic logic ref_expect_miss(input logic [31:0] addr);
        return find_way(addr) < 0;
    endfunction

    task automatic model_update(input dcache_kind_t kind, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] wstrb);
        int          idx;
        int          w;
        logic [31:0] word;
        idx = int'(addr[`DCACHE_TAG_LSB-1:`DCACHE_INDEX_LSB]);
        w   = find_way(addr);
        if (kind == kind_store) begin
            word = ref_load_word(addr);
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    word[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            shadow[{addr[31:2], 2'b00}] = word;
        end else if (w < 0) begin
            // load miss fills the LRU way
            w = int'(repl_m[idx]);
            tag_m[idx][w]   = addr[31:`DCACHE_TAG_LSB];
            valid_m[idx][w] = 1'b1;
        end
        if (w >= 0) begin
            repl_m[idx] = (w == 0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    function automatic void report_mismatch(input string name, input logic [31:0] expv,
                                            input logic [31:0] got);
        err_cnt++;
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expv, got);
    endfunction

    function automatic void report_failure(input string what);
        err_cnt++;
        $display("error at %0t ns: %s", $time, what);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // comparison process
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (arst_n) begin
            if (cpu_valid && cpu_ready) begin
                accept_cycle = cycle_cnt;
                rd_seen      = 0;
                wr_seen      = 0;
            end
            if (mem_req && mem_addr_ok) begin
                if (mem_wr) begin
                    wr_seen++;
                    assert (exp_kind == kind_store)
                    else report_failure("memory write issued for a load");
                    assert (mem_addr == exp_addr)
                    else report_mismatch("mem_addr", exp_addr, mem_addr);
                    assert (mem_wdata == exp_wdata)
                    else report_mismatch("mem_wdata", exp_wdata, mem_wdata);
                    assert (mem_wstrb == exp_wstrb)
                    else report_mismatch("mem_wstrb", 32'(exp_wstrb), 32'(mem_wstrb));
                end else begin
                    rd_seen++;
                    assert (exp_kind == kind_load && exp_miss)
                    else report_failure("line read issued although a hit or store was expected");
                    assert (mem_addr == {exp_addr[31:`DCACHE_INDEX_LSB], 4'b0000})
                    else report_mismatch("mem_addr", {exp_addr[31:4], 4'b0000}, mem_addr);
                end
            end
            if (resp_valid) begin
                assert (pending) else report_failure("resp_valid with no request in flight");
                if (exp_kind == kind_load) begin
                    assert (resp_rdata == exp_data)
                    else report_mismatch("resp_rdata", exp_data, resp_rdata);
                    assert (rd_seen == (exp_miss ? 1 : 0))
                    else report_failure("line read count does not match the predicted miss");
                    if (!exp_miss) begin
                        assert (cycle_cnt - accept_cycle == 1)
                        else report_failure("load hit did not respond one cycle after accept");
                    end
                end else begin
                    assert (wr_seen == 1 && rd_seen == 0)
                    else report_failure("store did not issue exactly one write and no read");
                end
                pending = 1'b0;
                resp_cnt++;
            end
        end
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] make_addr(input logic [23:0] tag, input logic [3:0] idx,
                                              input logic [1:0] off);
        return {tag, idx, off, 2'b00};
    endfunction

    task automatic issue(input dcache_kind_t kind, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] wstrb);
        int target;
        do @(negedge clk); while (!cpu_ready);
        exp_kind  = kind;
        exp_addr  = addr;
        exp_wdata = wdata;
        exp_wstrb = wstrb;
        exp_data  = ref_load_word(addr);
        exp_miss  = ref_expect_miss(addr);
        pending   = 1'b1;
        model_update(kind, addr, wdata, wstrb);
        target    = resp_cnt + 1;
        cpu_valid = 1'b1;
        cpu_kind  = kind;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_wstrb = wstrb;
        @(negedge clk);
        cpu_valid = 1'b0;
        cpu_addr  = $urandom;
        while (resp_cnt < target) @(negedge clk);
    endtask

    initial begin
        logic [31:0] a;
        void'($urandom(33));
        cpu_valid = 1'b0;
        cpu_kind  = kind_load;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        pending   = 1'b0;
        exp_kind  = kind_load;
        resp_cnt  = 0;
        err_cnt   = 0;
        cycle_cnt = 0;
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            repl_m[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                valid_m[s][w] = 1'b0;
                tag_m[s][w]   = '0;
            end
        end
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (cpu_ready && !resp_valid && !mem_req)
        else report_failure("cache not idle after reset");

        // first load misses, repeats hit
        a = make_addr(24'h000100, 4'h3, 2'd1);
        issue(kind_load, a, '0, '0);
        issue(kind_load, a, '0, '0);
        issue(kind_load, make_addr(24'h000100, 4'h3, 2'd2), '0, '0);

        // store hit merges, then load reads it back
        issue(kind_store, a, $urandom, 4'($urandom_range(1, 15)));
        issue(kind_load, a, '0, '0);

        // store miss must not allocate
        a = make_addr(24'h000777, 4'h9, 2'd0);
        issue(kind_store, a, $urandom, 4'($urandom_range(1, 15)));
        issue(kind_load, a, '0, '0);

        // three tags in set 5
        issue(kind_load, make_addr(24'h000010, 4'h5, 2'd0), '0, '0);
        issue(kind_load, make_addr(24'h000020, 4'h5, 2'd1), '0, '0);
        issue(kind_load, make_addr(24'h000010, 4'h5, 2'd2), '0, '0);
        issue(kind_load, make_addr(24'h000030, 4'h5, 2'd3), '0, '0);
        issue(kind_load, make_addr(24'h000020, 4'h5, 2'd0), '0, '0);
        issue(kind_load, make_addr(24'h000010, 4'h5, 2'd0), '0, '0);

        // mixed traffic over a few sets
        for (int i = 0; i < RANDOM_TXNS; i++) begin
            a = make_addr(24'h000200 + 24'($urandom_range(0, 3)),
                          4'($urandom_range(0, 3)), 2'($urandom_range(0, 3)));
            if ($urandom_range(0, 2) == 0) begin
                issue(kind_store, a, $urandom, 4'($urandom_range(1, 15)));
            end else begin
                issue(kind_load, a, '0, '0);
            end
        end

        repeat (5) @(negedge clk);
        assert (cpu_ready && !mem_req) else report_failure("cache not idle at the end of the run");
        $display("checks done: %0d errors over %0d responses", err_cnt, resp_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_req_buffer.sv
logic/dcache_way.sv
logic/dcache_way_merge.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module dcache_tb -o dcache_sim \
    && ./obj_dir/dcache_sim | tee /dev/stderr | grep -qx "TB PASSED" \
    && exit 0 \
    || exit 1
